//--- source/gearbox_settings.svh
// Stream widths, BAR-hit width and heartbeat counter bit
`ifndef GEARBOX_SETTINGS_SVH
`define GEARBOX_SETTINGS_SVH

// Dword and beat sizes
`define GB_DW_BITS          32
`define GB_CORE_DWS         2
`define GB_TLPS_DWS         4
`define GB_CORE_BITS        (`GB_DW_BITS * `GB_CORE_DWS)
`define GB_TLPS_BITS        (`GB_DW_BITS * `GB_TLPS_DWS)

// BAR-hit field carried alongside each beat
`define GB_BAR_BITS         7

// Counter bit that blinks the LED while the link is down
`define GB_HEARTBEAT_BIT    25

`endif

//--- source/tlp_gearbox_pkg.sv
// Beat structs for the 64-bit core and 128-bit application streams
// and the link-state enum
`include "gearbox_settings.svh"

package tlp_gearbox_pkg;

    // ------------------------------------------------------------
    // Core side beat, byte granular keep
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`GB_CORE_BITS-1:0]       data;
        logic [`GB_CORE_DWS*4-1:0]      keep;
        logic                           last;
        logic [`GB_BAR_BITS-1:0]        bar_hit;
    } core_beat_t;

    // ------------------------------------------------------------
    // Application side beat, one keep bit per dword
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`GB_TLPS_BITS-1:0]       data;
        logic [`GB_TLPS_DWS-1:0]        keep_dw;
        // Start of packet
        logic                           first;
        logic                           last;
        logic [`GB_BAR_BITS-1:0]        bar_hit;
    } tlps_beat_t;

    // Link tracking FSM
    typedef enum logic [1:0] {
        LINK_RESET    = 2'd0,
        LINK_TRAINING = 2'd1,
        LINK_UP       = 2'd2
    } link_state_e;

endpackage

//--- source/link_ctrl.sv
// Subsystem reset merge, link-state FSM and heartbeat LED
`include "gearbox_settings.svh"

module link_ctrl #(
    parameter int heartbeat_bit = `GB_HEARTBEAT_BIT
) (
    input  logic                        clk_pcie,
    input  logic                        rst,
    input  logic                        core_user_rst,
    input  logic                        subsys_rst_req,
    input  logic                        link_up,
    output logic                        rst_subsys,
    output tlp_gearbox_pkg::link_state_e link_state,
    output logic                        led_state
);
    import tlp_gearbox_pkg::*;

    logic [heartbeat_bit:0] heartbeat_cnt;

    // Any reset source takes the subsystem down on the next edge
    always_ff @(posedge clk_pcie) begin
        rst_subsys <= rst | core_user_rst | subsys_rst_req;
    end

    // ------------------------------------------------------------
    // Link state
    // ------------------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst || rst_subsys) begin
            link_state <= LINK_RESET;
        end else begin
            case (link_state)
                LINK_RESET:    link_state <= LINK_TRAINING;
                LINK_TRAINING: link_state <= link_up ? LINK_UP : LINK_TRAINING;
                LINK_UP:       link_state <= link_up ? LINK_UP : LINK_TRAINING;
                default:       link_state <= LINK_RESET;
            endcase
        end
    end

    // Free running, blinks the LED until the link comes up
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            heartbeat_cnt <= '0;
        end else begin
            heartbeat_cnt <= heartbeat_cnt + 1'b1;
        end
    end

    assign led_state = (link_state == LINK_UP) || heartbeat_cnt[heartbeat_bit];

endmodule

//--- source/tlp_rx_upsizer.sv
// Receive packer from 64-bit core beats to 128-bit application beats
`include "gearbox_settings.svh"

module tlp_rx_upsizer (
    input  logic                        clk_pcie,
    input  logic                        rst_subsys,
    input  logic                        rx_valid,
    input  tlp_gearbox_pkg::core_beat_t rx_beat,
    output logic                        rx_ready,
    output logic                        rxw_valid,
    output tlp_gearbox_pkg::tlps_beat_t rxw_beat
);
    import tlp_gearbox_pkg::*;

    localparam int fill_bits = $clog2(`GB_TLPS_DWS + 1);

    logic [`GB_TLPS_BITS-1:0]   buf_data;
    logic [fill_bits-1:0]       fill;
    logic                       first_q;
    logic                       last_q;
    logic [`GB_BAR_BITS-1:0]    bar_hit_q;

    logic                       out_valid;
    logic [fill_bits-1:0]       next_base;
    logic [fill_bits-1:0]       next_fill;
    logic [`GB_TLPS_DWS-1:0]    keep_dw;

    // Wide beat goes out once it has three dwords or the packet ended
    assign out_valid = last_q || (fill > 2);

    // Restart at dword 0 when the buffer is emitted this cycle
    assign next_base = out_valid ? '0 : fill;
    // Second dword present when byte 4 is kept
    assign next_fill = next_base + fill_bits'(1) + fill_bits'(rx_beat.keep[4]);

    always_comb begin
        for (int n = 0; n < `GB_TLPS_DWS; n++) begin
            keep_dw[n] = (fill > n);
        end
    end

    // ------------------------------------------------------------
    // Fill tracking and buffer write
    // ------------------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst_subsys) begin
            fill    <= '0;
            first_q <= 1'b1;
            last_q  <= 1'b0;
        end else if (rx_valid) begin
            fill    <= next_fill;
            // Next wide beat opens a packet only if the emitted one closed it
            first_q <= out_valid ? last_q : first_q;
            last_q  <= rx_beat.last;
        end else if (out_valid) begin
            fill    <= '0;
            first_q <= last_q;
            last_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rx_valid) begin
            buf_data[next_base*`GB_DW_BITS +: `GB_CORE_BITS] <= rx_beat.data;
            bar_hit_q <= rx_beat.bar_hit;
        end
    end

    // No back-pressure toward the core
    assign rx_ready = 1'b1;

    assign rxw_valid        = out_valid;
    assign rxw_beat.data    = buf_data;
    assign rxw_beat.keep_dw = keep_dw;
    assign rxw_beat.first   = first_q;
    assign rxw_beat.last    = last_q;
    assign rxw_beat.bar_hit = bar_hit_q;

endmodule

//--- source/tlp_tx_downsizer.sv
// Transmit splitter from 128-bit application beats to 64-bit core beats
`include "gearbox_settings.svh"

module tlp_tx_downsizer (
    input  logic                        clk_pcie,
    input  logic                        rst,
    input  logic                        txw_valid,
    input  tlp_gearbox_pkg::tlps_beat_t txw_beat,
    input  logic                        tx_ready,
    output logic                        txw_ready,
    output logic                        tx_valid,
    output tlp_gearbox_pkg::core_beat_t tx_beat
);
    import tlp_gearbox_pkg::*;

    localparam logic [`GB_CORE_DWS*4-1:0] keep_full = '1;
    localparam logic [`GB_CORE_DWS*4-1:0] keep_low  = keep_full >> 4;

    // Upper half waiting for the core
    logic                       hold_valid;
    logic [`GB_CORE_BITS-1:0]   hold_data;
    logic                       hold_dw3;
    logic                       hold_last;
    logic [`GB_BAR_BITS-1:0]    hold_bar_hit;

    logic                       upper_follows;

    assign upper_follows = txw_valid && txw_beat.keep_dw[2];

    // Wide beat with an upper half is released only after that half goes out
    assign txw_ready = tx_ready && (hold_valid || !upper_follows);

    // ------------------------------------------------------------
    // Output select, lower half passes straight through
    // ------------------------------------------------------------
    assign tx_valid = hold_valid || txw_valid;

    always_comb begin
        if (hold_valid) begin
            tx_beat.data    = hold_data;
            tx_beat.keep    = hold_dw3 ? keep_full : keep_low;
            tx_beat.last    = hold_last;
            tx_beat.bar_hit = hold_bar_hit;
        end else begin
            tx_beat.data    = txw_beat.data[`GB_CORE_BITS-1:0];
            tx_beat.keep    = txw_beat.keep_dw[1] ? keep_full : keep_low;
            tx_beat.last    = txw_beat.last && !txw_beat.keep_dw[2];
            tx_beat.bar_hit = txw_beat.bar_hit;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (hold_valid) begin
            hold_valid <= !tx_ready;
        end else begin
            hold_valid <= upper_follows && tx_ready;
        end
    end

    // Capture the upper half as the lower half is taken
    always_ff @(posedge clk_pcie) begin
        if (!hold_valid && upper_follows && tx_ready) begin
            hold_data    <= txw_beat.data[`GB_TLPS_BITS-1:`GB_CORE_BITS];
            hold_dw3     <= txw_beat.keep_dw[3];
            hold_last    <= txw_beat.last;
            hold_bar_hit <= txw_beat.bar_hit;
        end
    end

endmodule

//--- source/tlp_gearbox_top.sv
// Gearbox top level with link control and both stream datapaths
`include "gearbox_settings.svh"

module tlp_gearbox_top #(
    parameter int heartbeat_bit = `GB_HEARTBEAT_BIT
) (
    input  logic                         clk_pcie,
    input  logic                         rst,
    // Receive, core to application
    input  logic                         rx_valid,
    input  tlp_gearbox_pkg::core_beat_t  rx_beat,
    output logic                         rx_ready,
    output logic                         rxw_valid,
    output tlp_gearbox_pkg::tlps_beat_t  rxw_beat,
    // Transmit, application to core
    input  logic                         txw_valid,
    input  tlp_gearbox_pkg::tlps_beat_t  txw_beat,
    output logic                         txw_ready,
    output logic                         tx_valid,
    output tlp_gearbox_pkg::core_beat_t  tx_beat,
    input  logic                         tx_ready,
    // Control and status
    input  logic                         core_user_rst,
    input  logic                         subsys_rst_req,
    input  logic                         link_up,
    output logic                         led_state,
    output tlp_gearbox_pkg::link_state_e link_state
);
    import tlp_gearbox_pkg::*;

    logic rst_subsys;

    // ------------------------------------------------------------
    // Reset merge and link status
    // ------------------------------------------------------------
    link_ctrl #(
        .heartbeat_bit  (heartbeat_bit)
    ) u_link_ctrl (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .core_user_rst  (core_user_rst),
        .subsys_rst_req (subsys_rst_req),
        .link_up        (link_up),
        .rst_subsys     (rst_subsys),
        .link_state     (link_state),
        .led_state      (led_state)
    );

    // Receive side runs on the subsystem reset
    tlp_rx_upsizer u_rx_upsizer (
        .clk_pcie       (clk_pcie),
        .rst_subsys     (rst_subsys),
        .rx_valid       (rx_valid),
        .rx_beat        (rx_beat),
        .rx_ready       (rx_ready),
        .rxw_valid      (rxw_valid),
        .rxw_beat       (rxw_beat)
    );

    // Transmit side stays on the system reset
    tlp_tx_downsizer u_tx_downsizer (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .txw_valid      (txw_valid),
        .txw_beat       (txw_beat),
        .tx_ready       (tx_ready),
        .txw_ready      (txw_ready),
        .tx_valid       (tx_valid),
        .tx_beat        (tx_beat)
    );

endmodule

//--- dv/tlp_gearbox_checker.sv
// Concurrent assertions on the core stream ports, bound into the top level
`include "gearbox_settings.svh"

module tlp_gearbox_checker (
    input logic                        clk_pcie,
    input logic                        rst,
    input logic                        rx_ready,
    input logic                        tx_valid,
    input logic                        tx_ready,
    input tlp_gearbox_pkg::core_beat_t tx_beat
);
    int fail_cnt = 0;

    a_rx_ready: assert property (@(posedge clk_pcie) disable iff (rst) rx_ready)
        else begin
            fail_cnt++;
            $error("rx_ready went low");
        end

    // Full beat or low dword only
    a_tx_keep: assert property (@(posedge clk_pcie) disable iff (rst)
        tx_valid |-> (tx_beat.keep == 8'hff || tx_beat.keep == 8'h0f))
        else begin
            fail_cnt++;
            $error("illegal tx_beat byte keep 0x%02h", tx_beat.keep);
        end

    a_tx_stable: assert property (@(posedge clk_pcie) disable iff (rst)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_beat)))
        else begin
            fail_cnt++;
            $error("tx_beat changed while stalled");
        end

endmodule

bind tlp_gearbox_top tlp_gearbox_checker u_checker (
    .clk_pcie (clk_pcie),
    .rst      (rst),
    .rx_ready (rx_ready),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_beat  (tx_beat)
);

//--- dv/tb_monitor.sv
// Output monitor with packet reassembly, comparison and link state checks
`include "gearbox_settings.svh"

module tb_monitor #(
    parameter int hb_bit = 4
) (
    input  logic                         clk_pcie,
    input  logic                         rst,
    input  logic                         rst_subsys,
    input  logic                         link_up,
    input  logic                         rxw_valid,
    input  tlp_gearbox_pkg::tlps_beat_t  rxw_beat,
    input  logic                         txw_ready,
    input  logic                         tx_valid,
    input  logic                         tx_ready,
    input  tlp_gearbox_pkg::core_beat_t  tx_beat,
    input  logic                         led_state,
    input  tlp_gearbox_pkg::link_state_e link_state,
    input  logic                         exp_push,
    input  logic                         exp_is_tx,
    input  logic [3:0]                   exp_len,
    input  logic [`GB_BAR_BITS-1:0]      exp_bar,
    input  logic [31:0]                  exp_start,
    input  logic [2:0]                   exp_tail,
    output int                           error_count,
    output int                           test_count,
    output int                           pending
);
    import tlp_gearbox_pkg::*;

    // Expected packets per direction with the one in flight at the head
    int          len_q[2][$];
    logic [6:0]  bar_q[2][$];
    logic [31:0] start_q[2][$];
    int          tail_q[2][$];
    logic [31:0] got_dw[2][$];
    int          err_at_start[2];
    bit          link_done = 0;

    initial begin
        error_count = 0;
        test_count = 0;
    end

    function automatic void fail_value(string name, logic [31:0] got, logic [31:0] exp);
        $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        error_count++;
    endfunction

    function automatic void fail_text(string msg);
        $display("ERROR %s", msg);
        error_count++;
    endfunction

    function automatic void report(string name, int err_start);
        test_count++;
        $display("test %0d %s: %s", test_count, name, (error_count == err_start) ? "ok" : "bad");
    endfunction

    // Beat from either side where d is 0 for receive and 1 for transmit
    function automatic void take_beat(int d, logic [127:0] data, logic [3:0] keep,
                                      logic first, logic last, logic [6:0] bar);
        string nm;
        nm = d ? "tx_beat" : "rxw_beat";
        if (len_q[d].size() == 0) begin
            fail_text($sformatf("%s beat arrived with no packet expected", nm));
            return;
        end
        if (got_dw[d].size() == 0)
            err_at_start[d] = error_count;
        if (d == 0 && first !== (got_dw[d].size() == 0))
            fail_value("rxw_beat.first", first, got_dw[d].size() == 0);
        if (bar !== bar_q[d][0])
            fail_value($sformatf("%s.bar_hit", nm), bar, bar_q[d][0]);
        for (int k = 0; k < 4; k++) begin
            if (keep[k])
                got_dw[d].push_back(data[k*32 +: 32]);
        end
        if (last || got_dw[d].size() >= len_q[d][0]) begin
            if (!last)
                fail_text($sformatf("%s packet reached its length without last", nm));
            if ($countones(keep) != tail_q[d][0])
                fail_value($sformatf("%s final dword count", nm), $countones(keep),
                           tail_q[d][0]);
            if (got_dw[d].size() != len_q[d][0])
                fail_value($sformatf("%s dword count", nm), got_dw[d].size(), len_q[d][0]);
            for (int i = 0; i < got_dw[d].size() && i < len_q[d][0]; i++) begin
                if (got_dw[d][i] !== start_q[d][0] + i)
                    fail_value($sformatf("%s dword %0d", nm, i), got_dw[d][i],
                               start_q[d][0] + i);
            end
            report($sformatf("%s packet of %0d dwords", d ? "tx" : "rx", len_q[d][0]),
                   err_at_start[d]);
            got_dw[d].delete();
            void'(len_q[d].pop_front());
            void'(bar_q[d].pop_front());
            void'(start_q[d].pop_front());
            void'(tail_q[d].pop_front());
        end
    endfunction

    // ------------------------------------------------------------
    // Stream sampling
    // ------------------------------------------------------------
    always @(posedge clk_pcie) begin
        if (exp_push) begin
            len_q[exp_is_tx].push_back(exp_len);
            bar_q[exp_is_tx].push_back(exp_bar);
            start_q[exp_is_tx].push_back(exp_start);
            tail_q[exp_is_tx].push_back(exp_tail);
        end
        if (!rst) begin
            if (rxw_valid && rst_subsys)
                fail_text("rxw_valid was high during the subsystem reset");
            else if (rxw_valid)
                take_beat(0, rxw_beat.data, rxw_beat.keep_dw, rxw_beat.first,
                          rxw_beat.last, rxw_beat.bar_hit);
            if (txw_ready && !tx_ready)
                fail_text("txw_ready was high while tx_ready was low");
            if (tx_valid && tx_ready) begin
                if (tx_beat.keep == 8'h0f && !tx_beat.last)
                    fail_value("tx_beat.last", 0, 1);
                take_beat(1, {64'h0, tx_beat.data}, {2'b00, tx_beat.keep[4], 1'b1},
                          1'b0, tx_beat.last, tx_beat.bar_hit);
            end
        end
    end

    always @(negedge clk_pcie) begin
        pending = len_q[0].size() + len_q[1].size() + (link_done ? 0 : 1);
    end

    // Link FSM and heartbeat LED
    initial begin : link_checks
        int   waited;
        int   e0;
        logic led_prev;
        @(negedge rst);
        @(negedge clk_pcie);
        e0 = error_count;
        if (link_state !== LINK_RESET)
            fail_value("link_state", link_state, LINK_RESET);
        waited = 0;
        while (link_state !== LINK_TRAINING && waited < 4) begin
            @(negedge clk_pcie);
            waited++;
        end
        if (link_state !== LINK_TRAINING)
            fail_value("link_state", link_state, LINK_TRAINING);
        led_prev = led_state;
        waited = 0;
        while (led_state === led_prev && waited < (1 << (hb_bit + 1))) begin
            @(negedge clk_pcie);
            waited++;
        end
        if (led_state === led_prev)
            fail_text("led_state did not toggle while the link was down");
        report("link reset and heartbeat", e0);
        @(posedge link_up);
        e0 = error_count;
        repeat (3) @(negedge clk_pcie);
        repeat (8) begin
            if (link_state !== LINK_UP)
                fail_value("link_state", link_state, LINK_UP);
            if (led_state !== 1'b1)
                fail_value("led_state", led_state, 1);
            @(negedge clk_pcie);
        end
        report("link up and LED on", e0);
        link_done = 1;
    end

endmodule

//--- dv/tb_top.sv
// Testbench top with clock, reset, packet table, stream drivers, timeout and report
`include "gearbox_settings.svh"

module tb_top;
    import tlp_gearbox_pkg::*;

    localparam int hb_bit = 4;
    localparam int n_rows = 15;

    // tail is the dword count of the last output beat
    typedef struct packed {
        logic                    is_tx;
        logic                    abort;
        logic [3:0]              len;
        logic [`GB_BAR_BITS-1:0] bar;
        logic [31:0]             start;
        logic [1:0]              stall;
        logic [2:0]              tail;
    } row_t;

    logic clk_pcie, rst, rx_valid, rx_ready, rxw_valid, txw_valid, txw_ready;
    logic tx_valid, tx_ready, core_user_rst, subsys_rst_req, link_up, led_state;
    core_beat_t  rx_beat, tx_beat;
    tlps_beat_t  rxw_beat, txw_beat;
    link_state_e link_state;
    logic        exp_push;
    row_t        exp_row;
    row_t        rows [n_rows];
    int          error_count, test_count, pending, cycles, limit, stall_level;

    tlp_gearbox_top #(.heartbeat_bit(hb_bit)) u_dut (.*);

    tb_monitor #(.hb_bit(hb_bit)) u_monitor (
        .clk_pcie (clk_pcie), .rst (rst), .rst_subsys (u_dut.rst_subsys),
        .link_up (link_up), .rxw_valid (rxw_valid), .rxw_beat (rxw_beat),
        .txw_ready (txw_ready), .tx_valid (tx_valid), .tx_ready (tx_ready),
        .tx_beat (tx_beat), .led_state (led_state), .link_state (link_state),
        .exp_push (exp_push), .exp_is_tx (exp_row.is_tx), .exp_len (exp_row.len),
        .exp_bar (exp_row.bar), .exp_start (exp_row.start), .exp_tail (exp_row.tail),
        .error_count (error_count), .test_count (test_count), .pending (pending)
    );

    initial begin
        clk_pcie = 1'b0;
        forever #5 clk_pcie = ~clk_pcie;
    end

    // Core stalls redrawn each cycle
    always @(posedge clk_pcie) begin
        #1;
        tx_ready = (stall_level == 0) || (($urandom % 4) >= stall_level);
    end

    always @(posedge clk_pcie) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, %0d checks still pending", cycles, pending);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic row_t make_row(logic t, logic a, int len, int bar, int start, int st,
                                      int tl);
        return '{t, a, len[3:0], bar[6:0], start, st[1:0], tl[2:0]};
    endfunction

    task automatic announce(row_t r);
        exp_row = r;
        exp_push = 1'b1;
        @(posedge clk_pcie);
        #1;
        exp_push = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Receive driver with an optional mid-packet subsystem reset
    // ------------------------------------------------------------
    task automatic drive_rx(row_t r);
        int nb;
        nb = r.abort ? 1 : (r.len + 1) / 2;
        for (int k = 0; k < nb; k++) begin
            rx_beat = '0;
            rx_beat.data[31:0] = r.start + 2 * k;
            rx_beat.keep = (2 * k + 1 < r.len) ? 8'hff : 8'h0f;
            if (2 * k + 1 < r.len)
                rx_beat.data[63:32] = r.start + 2 * k + 1;
            rx_beat.last = !r.abort && (k == nb - 1);
            rx_beat.bar_hit = r.bar;
            rx_valid = 1'b1;
            @(posedge clk_pcie);
            #1;
            rx_valid = 1'b0;
            repeat ($urandom % (r.stall + 1)) begin
                @(posedge clk_pcie);
                #1;
            end
        end
        if (r.abort) begin
            subsys_rst_req = 1'b1;
            @(posedge clk_pcie);
            #1;
            subsys_rst_req = 1'b0;
            repeat (4) @(posedge clk_pcie);
            #1;
        end
    endtask

    task automatic drive_tx(row_t r);
        int nb;
        nb = (r.len + 3) / 4;
        stall_level = r.stall;
        for (int k = 0; k < nb; k++) begin
            txw_beat = '0;
            for (int d = 0; d < 4; d++) begin
                if (4 * k + d < r.len) begin
                    txw_beat.data[d*32 +: 32] = r.start + 4 * k + d;
                    txw_beat.keep_dw[d] = 1'b1;
                end
            end
            txw_beat.first = (k == 0);
            txw_beat.last = (k == nb - 1);
            txw_beat.bar_hit = r.bar;
            txw_valid = 1'b1;
            @(posedge clk_pcie);
            while (!txw_ready)
                @(posedge clk_pcie);
            #1;
        end
        txw_valid = 1'b0;
        txw_beat = '0;
    endtask

    initial begin
        rst = 1'b1;
        {rx_valid, txw_valid, core_user_rst, subsys_rst_req, link_up, exp_push} = '0;
        tx_ready = 1'b1;
        rx_beat = '0;
        txw_beat = '0;
        exp_row = '0;
        stall_level = 0;
        cycles = 0;
        limit = 0;
        void'($urandom(17));
        rows[0]  = make_row(0, 0, 1, 'h01, 'h1000_0000, 0, 1);
        rows[1]  = make_row(0, 0, 2, 'h02, 'h2000_0000, 1, 2);
        rows[2]  = make_row(0, 0, 3, 'h04, 'h3000_0000, 0, 3);
        rows[3]  = make_row(0, 0, 4, 'h08, 'h4000_0000, 2, 4);
        rows[4]  = make_row(0, 0, 5, 'h10, 'h5000_0000, 0, 1);
        rows[5]  = make_row(0, 0, 7, 'h20, 'h6000_0000, 1, 3);
        rows[6]  = make_row(0, 0, 8, 'h40, 'h7000_0000, 3, 4);
        rows[7]  = make_row(0, 1, 6, 'h11, 'h8000_0000, 0, 0);
        rows[8]  = make_row(0, 0, 6, 'h12, 'h9000_0000, 2, 2);
        rows[9]  = make_row(1, 0, 1, 'h21, 'ha000_0000, 0, 1);
        rows[10] = make_row(1, 0, 3, 'h22, 'hb000_0000, 0, 1);
        rows[11] = make_row(1, 0, 4, 'h23, 'hc000_0000, 1, 2);
        rows[12] = make_row(1, 0, 6, 'h24, 'hd000_0000, 1, 2);
        rows[13] = make_row(1, 0, 8, 'h25, 'he000_0000, 2, 2);
        rows[14] = make_row(1, 0, 7, 'h26, 'hf000_0000, 2, 1);
        for (int i = 0; i < n_rows; i++)
            limit += rows[i].len * 4;
        limit += 200;
        repeat (4) @(posedge clk_pcie);
        #1;
        rst = 1'b0;
        repeat (40) @(posedge clk_pcie);
        #1;
        link_up = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            if (!rows[i].abort)
                announce(rows[i]);
            if (rows[i].is_tx)
                drive_tx(rows[i]);
            else
                drive_rx(rows[i]);
        end
        stall_level = 0;
        while (pending != 0)
            @(posedge clk_pcie);
        repeat (4) @(posedge clk_pcie);
        $display("%0d tests, %0d errors, %0d assertion failures", test_count, error_count,
                 u_dut.u_checker.fail_cnt);
        if (error_count == 0 && u_dut.u_checker.fail_cnt == 0 && test_count == n_rows + 1)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- pcie_tlp_gearbox.f
+incdir+source
source/tlp_gearbox_pkg.sv
source/link_ctrl.sv
source/tlp_rx_upsizer.sv
source/tlp_tx_downsizer.sv
source/tlp_gearbox_top.sv
dv/tlp_gearbox_checker.sv
dv/tb_monitor.sv
dv/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build the gearbox testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f pcie_tlp_gearbox.f -o tb_sim \
    && ./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
